// File: src.f
+incdir+src
src/fetch_pkg.sv
src/refill_if.sv
src/fetch_stage.sv
src/icache_array.sv
src/refill_fsm.sv
src/refill_word_counter.sv
src/fetch_top.sv
sim/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module fetch_tb -o fetch_sim --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/fetch_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench prints its verdict on a line of its own
if echo "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1

// File: sim/fetch_tests.txt
// image: entry count, then address and instruction word pairs, all hex
// steps: count, then take_branch target_pc dis_stall wait_cycles exp_pc2 refetch
00000008
00000000 00500093
00000004 00a00113
00000008 002081b3
0000000c 40208233
00000010 0041a2b3
000001a0 0ff00393
000002a4 fe0004e3
000003e8 00000013
0000000d
0 00000000 0 40 00000000 0
0 00000000 1 40 00000008 0
0 00000000 2 40 0000000c 0
0 00000000 4 40 0000000c 0
1 000001a0 0 40 000001a0 0
1 000002a4 0 40 000002a4 0
1 00000000 0 4 00000000 1
1 000001a0 0 40 000001a0 0
0 00000000 4 40 000001a0 0
1 00000008 0 4 00000008 1
0 00000000 1 40 00000010 0
1 000003e8 0 40 000003e8 0
1 00000000 0 4 00000000 1

// File: sim/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_tb;

    logic                                 clock;
    logic                                 reset;
    logic                                 take_branch;
    fetch_pkg::addr_t                     target_pc;
    logic [`FETCH_WIDTH-1:0]              dis_stall;
    logic                                 mem_req;
    fetch_pkg::addr_t                     mem_addr;
    logic                                 mem_ack;
    fetch_pkg::inst_t                     mem_data;
    logic [`FETCH_WIDTH-1:0]              if_valid;
    fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  if_pc;
    fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  if_npc;
    fetch_pkg::inst_t [`FETCH_WIDTH-1:0]  if_inst;

    logic [31:0]       tests [0:127];                // raw words of the data file
    fetch_pkg::inst_t  image [fetch_pkg::addr_t];    // listed memory words
    fetch_pkg::addr_t  req_log [$];                  // every address memory answered
    int                errors = 0;
    int                timeouts = 0;
    int                seed = 61;
    logic              have_prev = 1'b0;
    fetch_pkg::addr_t  exp_next_pc2;                 // slot 2 pc due after the next edge

    fetch_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // unlisted addresses read a pattern built from the whole address
    function automatic fetch_pkg::inst_t image_word(fetch_pkg::addr_t a);
        if (image.exists(a))
            return image[a];
        return a ^ {a[15:0], a[31:16]} ^ 32'h6b3c_91e5;
    endfunction

    // branch wins, then the oldest stalled or missing slot refetches, else run on
    function automatic fetch_pkg::addr_t next_oldest_pc(logic br, fetch_pkg::addr_t tgt,
            logic [2:0] stall, logic [2:0] valid, fetch_pkg::addr_t [2:0] pc);
        if (br) return tgt;
        if (stall[2] || !valid[2]) return pc[2];
        if (stall[1] || !valid[1]) return pc[1];
        if (stall[0] || !valid[0]) return pc[0];
        return pc[0] + 32'd4;
    endfunction

    task automatic report_error(string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // per-cycle checks at the falling edge, outputs settled
    always @(negedge clock) begin
        if (reset) begin
            have_prev = 1'b0;
        end else begin
            if (!have_prev && (if_pc[2] != 0 || if_pc[1] != 4 || if_pc[0] != 8))
                report_error($sformatf("pcs after reset %h %h %h", if_pc[2], if_pc[1], if_pc[0]));
            if (have_prev && if_pc[2] != exp_next_pc2)
                report_error($sformatf("slot 2 pc %h, expected %h", if_pc[2], exp_next_pc2));
            if (if_pc[1] != if_pc[2] + 4 || if_pc[0] != if_pc[1] + 4)
                report_error($sformatf("pcs %h %h %h not in word steps",
                                       if_pc[2], if_pc[1], if_pc[0]));
            if (!(if_valid inside {3'b000, 3'b100, 3'b110, 3'b111}))
                report_error($sformatf("if_valid %b is not a prefix", if_valid));
            if (!if_valid[2] && if_inst[2] != '0)
                report_error($sformatf("missing slot 2 shows inst %h", if_inst[2]));
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (if_npc[i] != if_pc[i] + 4)
                    report_error($sformatf("slot %0d npc %h for pc %h", i, if_npc[i], if_pc[i]));
                if (if_valid[i] && if_inst[i] != image_word(if_pc[i]))
                    report_error($sformatf("slot %0d pc %h inst %h, expected %h", i, if_pc[i],
                                           if_inst[i], image_word(if_pc[i])));
            end
            exp_next_pc2 = next_oldest_pc(take_branch, target_pc, dis_stall, if_valid, if_pc);
            have_prev = 1'b1;
        end
    end

    // memory side of the four-phase handshake, random answer delay
    initial begin
        int delay;
        int waited;
        mem_ack = 1'b0;
        mem_data = '0;
        forever begin
            @(posedge clock);
            #1;
            if (!reset && mem_req) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
                repeat (delay) @(posedge clock);
                #1;
                req_log.push_back(mem_addr);
                mem_data = image_word(mem_addr);
                mem_ack = 1'b1;
                waited = 0;
                while (mem_req && waited < 20) begin
                    @(posedge clock);
                    #1;
                    waited++;
                end
                if (mem_req) begin
                    $display("memory handshake stuck: mem_req still high 20 cycles after mem_ack");
                    timeouts++;
                end
                mem_ack = 1'b0;  // phase 4
            end
        end
    end

    initial begin
        int n_image;
        int n_steps;
        int pos;
        int limit;
        int waited;
        int log_start;
        logic refetch;
        fetch_pkg::addr_t exp_pc2;
        reset = 1'b1;
        take_branch = 1'b0;
        target_pc = '0;
        dis_stall = '0;
        n_steps = 0;
        pos = 0;
        $readmemh("sim/fetch_tests.txt", tests);
        if ($isunknown(tests[0])) begin
            $display("no words could be read from sim/fetch_tests.txt");
            errors++;
        end else begin
            n_image = int'(tests[0]);
            for (int i = 0; i < n_image; i++)
                image[tests[1 + 2*i]] = tests[2 + 2*i];
            pos = 1 + 2*n_image;
            n_steps = int'(tests[pos]);
            pos++;
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int s = 0; s < n_steps; s++) begin
            take_branch = tests[pos][0];
            target_pc = tests[pos+1];
            dis_stall = tests[pos+2][`FETCH_WIDTH-1:0];
            limit = int'(tests[pos+3]);
            exp_pc2 = tests[pos+4];
            refetch = tests[pos+5][0];
            pos += 6;
            log_start = req_log.size();
            @(posedge clock);  // step applied on this edge
            #1;
            take_branch = 1'b0;
            dis_stall = '0;
            waited = 0;
            while (!if_valid[2] && waited < limit) begin
                @(posedge clock);
                #1;
                waited++;
            end
            if (!if_valid[2]) begin
                $display("step %0d timed out, slot 2 never valid within %0d cycles", s, limit);
                timeouts++;
                break;
            end
            if (if_pc[2] != exp_pc2)
                report_error($sformatf("step %0d slot 2 pc %h, expected %h", s, if_pc[2], exp_pc2));
            for (int r = log_start; refetch && r < req_log.size(); r++)
                if (req_log[r][31:3] == exp_pc2[31:3])
                    report_error($sformatf("step %0d refetch went to memory at %h", s, req_log[r]));
        end
        repeat (30) @(posedge clock);  // free run over filled lines
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_top (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 take_branch,
    input  fetch_pkg::addr_t                     target_pc,
    input  logic [`FETCH_WIDTH-1:0]              dis_stall,
    output logic                                 mem_req,     // four-phase memory port
    output fetch_pkg::addr_t                     mem_addr,
    input  logic                                 mem_ack,
    input  fetch_pkg::inst_t                     mem_data,
    output logic [`FETCH_WIDTH-1:0]              if_valid,    // packets to dispatch
    output fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  if_pc,
    output fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  if_npc,
    output fetch_pkg::inst_t [`FETCH_WIDTH-1:0]  if_inst
);

    // fetch stage to cache
    fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  cache_addr;
    fetch_pkg::inst_t [`FETCH_WIDTH-1:0]  cache_data;
    logic [`FETCH_WIDTH-1:0]              cache_valid;

    refill_if rf ();  // miss and fill path

    fetch_stage fetch0 (
        .clock       (clock),
        .reset       (reset),
        .take_branch (take_branch),
        .target_pc   (target_pc),
        .dis_stall   (dis_stall),
        .cache_data  (cache_data),
        .cache_valid (cache_valid),
        .cache_addr  (cache_addr),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_npc      (if_npc),
        .if_inst     (if_inst)
    );

    icache_array icache0 (
        .clock       (clock),
        .reset       (reset),
        .cache_addr  (cache_addr),
        .cache_data  (cache_data),
        .cache_valid (cache_valid),
        .rf          (rf)
    );

    refill_fsm refill0 (
        .clock    (clock),
        .reset    (reset),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data),
        .rf       (rf)
    );

    refill_word_counter counter0 (
        .clock (clock),
        .reset (reset),
        .rf    (rf)
    );

endmodule

// File: src/refill_word_counter.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module refill_word_counter (
    input  logic        clock,
    input  logic        reset,
    refill_if.counter   rf
);

    localparam fetch_pkg::word_sel_t final_word = fetch_pkg::word_sel_t'(`LINE_WORDS - 1);
    localparam fetch_pkg::word_sel_t one_word   = fetch_pkg::word_sel_t'(1);

    always_ff @(posedge clock) begin
        if (reset) begin
            rf.word_sel <= '0;
        end else if (rf.fill_en) begin
            rf.word_sel <= '0;                     // line written, start over
        end else if (rf.word_done) begin
            rf.word_sel <= rf.word_sel + one_word;
        end
    end

    assign rf.last_word = (rf.word_sel == final_word);

    // the FSM must not ask for a word beyond the line
    assert property (@(posedge clock) disable iff (reset)
        rf.word_done |-> (rf.word_sel != final_word))
    else
        $error("refill_word_counter: word_done on the last word of the line");

endmodule

// File: src/refill_fsm.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module refill_fsm (
    input  logic              clock,
    input  logic              reset,
    output logic              mem_req,
    output fetch_pkg::addr_t  mem_addr,
    input  logic              mem_ack,
    input  fetch_pkg::inst_t  mem_data,
    refill_if.fsm             rf
);

    fetch_pkg::refill_state_t            state;
    fetch_pkg::refill_state_t            next_state;
    fetch_pkg::addr_t                    line_addr;  // line being fetched
    fetch_pkg::inst_t [`LINE_WORDS-1:0]  line_buf;   // words collected so far

    always_comb begin
        next_state = state;
        case (state)
            fetch_pkg::IDLE:
                if (rf.miss)
                    next_state = fetch_pkg::REQ;
            fetch_pkg::REQ:
                if (mem_ack)
                    next_state = fetch_pkg::RELEASE;
            fetch_pkg::RELEASE:
                if (!mem_ack)  // handshake closed
                    next_state = rf.last_word ? fetch_pkg::WRITE : fetch_pkg::REQ;
            fetch_pkg::WRITE:
                next_state = fetch_pkg::IDLE;
            default:
                next_state = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetch_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // address latch and word capture
    always_ff @(posedge clock) begin
        if (state == fetch_pkg::IDLE && rf.miss) begin
            line_addr <= rf.miss_addr;
        end
        if (state == fetch_pkg::REQ && mem_ack) begin
            line_buf[rf.word_sel] <= mem_data;  // data valid with ack
        end
    end

    assign mem_req  = (state == fetch_pkg::REQ);
    assign mem_addr = line_addr + fetch_pkg::addr_t'({rf.word_sel, 2'b00});

    assign rf.fill_en   = (state == fetch_pkg::WRITE);
    assign rf.fill_data = line_buf;
    // no advance after the final word, the counter clears on fill_en instead
    assign rf.word_done = (state == fetch_pkg::RELEASE) && !mem_ack && !rf.last_word;

    // four-phase rule, request only falls once memory has answered
    assert property (@(posedge clock) disable iff (reset)
        $fell(mem_req) |-> $past(mem_ack))
    else
        $error("refill_fsm: mem_req dropped before mem_ack");

endmodule

// File: src/icache_array.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module icache_array (
    input  logic                                 clock,
    input  logic                                 reset,
    input  fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  cache_addr,
    output fetch_pkg::inst_t [`FETCH_WIDTH-1:0]  cache_data,
    output logic [`FETCH_WIDTH-1:0]              cache_valid,
    refill_if.cache                              rf
);

    // storage
    logic [`ICACHE_LINES-1:0]            line_valid;
    fetch_pkg::tag_t                     line_tag  [`ICACHE_LINES];
    fetch_pkg::inst_t [`LINE_WORDS-1:0]  line_data [`ICACHE_LINES];

    // per-slot lookup fields
    fetch_pkg::line_idx_t [`FETCH_WIDTH-1:0]  slot_idx;
    fetch_pkg::tag_t      [`FETCH_WIDTH-1:0]  slot_tag;
    fetch_pkg::word_sel_t [`FETCH_WIDTH-1:0]  slot_word;
    logic [`FETCH_WIDTH-1:0]                  slot_hit;
    logic                                     miss_found;

    // line under refill, taken when the FSM picks up the miss
    logic                  fill_busy;
    fetch_pkg::line_idx_t  fill_idx;
    fetch_pkg::tag_t       fill_tag;

    // three read ports, compared at once
    always_comb begin
        for (int s = 0; s < `FETCH_WIDTH; s++) begin
            slot_idx[s]    = cache_addr[s][`OFFSET_BITS +: `INDEX_BITS];
            slot_tag[s]    = cache_addr[s][`XLEN-1 : `OFFSET_BITS+`INDEX_BITS];
            slot_word[s]   = cache_addr[s][`OFFSET_BITS-1 -: $clog2(`LINE_WORDS)];
            slot_hit[s]    = line_valid[slot_idx[s]] && (line_tag[slot_idx[s]] == slot_tag[s]);
            cache_valid[s] = slot_hit[s];
            cache_data[s]  = line_data[slot_idx[s]][slot_word[s]];
        end
    end

    // oldest missing slot drives the refill request
    always_comb begin
        miss_found   = 1'b0;
        rf.miss_addr = '0;
        for (int s = `FETCH_WIDTH-1; s >= 0; s--) begin
            if (!miss_found && !slot_hit[s]) begin
                miss_found   = 1'b1;
                rf.miss_addr = {cache_addr[s][`XLEN-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
            end
        end
        rf.miss = miss_found;
    end

    // valid bits and refill tracking
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            fill_busy  <= 1'b0;
        end else begin
            if (rf.fill_en) begin
                line_valid[fill_idx] <= 1'b1;
                fill_busy            <= 1'b0;  // FSM back to idle next cycle
            end else if (rf.miss && !fill_busy) begin
                fill_busy <= 1'b1;             // FSM leaves idle on this edge
            end
        end
    end

    // tag and data, written whole
    always_ff @(posedge clock) begin
        if (rf.miss && !fill_busy) begin
            fill_idx <= rf.miss_addr[`OFFSET_BITS +: `INDEX_BITS];
            fill_tag <= rf.miss_addr[`XLEN-1 : `OFFSET_BITS+`INDEX_BITS];
        end
        if (rf.fill_en) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= rf.fill_data;
        end
    end

    // fill strobe only arrives for a refill this array saw start
    assert property (@(posedge clock) disable iff (reset) rf.fill_en |-> fill_busy)
    else
        $error("icache_array: fill_en without a refill in progress");

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_stage (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 take_branch,  // redirect this cycle
    input  fetch_pkg::addr_t                     target_pc,    // used when take_branch is set
    input  logic [`FETCH_WIDTH-1:0]              dis_stall,    // per-slot dispatch stall
    input  fetch_pkg::inst_t [`FETCH_WIDTH-1:0]  cache_data,
    input  logic [`FETCH_WIDTH-1:0]              cache_valid,  // per-slot hit
    output fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  cache_addr,
    output logic [`FETCH_WIDTH-1:0]              if_valid,
    output fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  if_pc,
    output fetch_pkg::addr_t [`FETCH_WIDTH-1:0]  if_npc,
    output fetch_pkg::inst_t [`FETCH_WIDTH-1:0]  if_inst
);

    localparam fetch_pkg::addr_t inst_bytes = 4;

    fetch_pkg::addr_t [`FETCH_WIDTH-1:0] pc_reg;      // pcs being fetched, [2] oldest
    fetch_pkg::addr_t [`FETCH_WIDTH-1:0] next_pc;
    logic                                hold_found;  // an older slot already chose the pc
    logic                                valid_chain; // every older slot so far is valid

    // oldest pc of the next group
    // branch target first, then the oldest stalled or missing slot, else youngest + 4
    always_comb begin
        hold_found = 1'b0;
        next_pc[`FETCH_WIDTH-1] = pc_reg[0] + inst_bytes;  // all slots move on
        for (int i = `FETCH_WIDTH-1; i >= 0; i--) begin
            if (!hold_found && (dis_stall[i] || !cache_valid[i])) begin
                hold_found = 1'b1;
                next_pc[`FETCH_WIDTH-1] = pc_reg[i];  // refetch from this slot
            end
        end
        if (take_branch) begin
            next_pc[`FETCH_WIDTH-1] = target_pc;
        end
        // younger slots follow in word steps
        for (int i = `FETCH_WIDTH-2; i >= 0; i--) begin
            next_pc[i] = next_pc[i+1] + inst_bytes;
        end
    end

    // pc triple, 0/4/8 after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                pc_reg[i] <= fetch_pkg::addr_t'((`FETCH_WIDTH - 1 - i) * 4);
            end
        end else begin
            pc_reg <= next_pc;
        end
    end

    assign cache_addr = pc_reg;  // all three slots looked up in parallel

    // output packets
    always_comb begin
        valid_chain = 1'b1;
        for (int i = `FETCH_WIDTH-1; i >= 0; i--) begin
            valid_chain = valid_chain & cache_valid[i];  // stops at first miss
            if_valid[i] = valid_chain;
            if_pc[i]    = pc_reg[i];
            if_npc[i]   = pc_reg[i] + inst_bytes;
            if_inst[i]  = cache_valid[i] ? cache_data[i] : '0;  // misses read as zero
        end
    end

    // invalid slots sit at the young end only,
    // so the inverted valid mask must look like 0..01..1
    assert property (@(posedge clock) disable iff (reset)
        ((~if_valid) & ((~if_valid) + 1'b1)) == '0)
    else
        $error("fetch_stage: if_valid %b is not a prefix from slot 2", if_valid);

endmodule

// File: src/refill_if.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

// miss path between the cache array, the refill FSM and the word counter
interface refill_if ();

    logic                                miss;        // level, some slot misses
    fetch_pkg::addr_t                    miss_addr;   // line address of oldest missing slot
    logic                                fill_en;     // one-cycle line write strobe
    fetch_pkg::inst_t [`LINE_WORDS-1:0]  fill_data;   // whole line, word 0 at index 0
    fetch_pkg::word_sel_t                word_sel;    // word currently being fetched
    logic                                word_done;   // advance to the next word
    logic                                last_word;   // word_sel is the final word

    modport cache (
        output miss, miss_addr,
        input  fill_en, fill_data
    );

    // word_sel comes from the counter, the FSM only reads it
    modport fsm (
        input  miss, miss_addr, last_word, word_sel,
        output fill_en, fill_data, word_done
    );

    modport counter (
        input  word_done, fill_en,
        output word_sel, last_word
    );

endinterface

// File: src/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // byte address or pc
    typedef logic [`XLEN-1:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // pc bits 7..3 pick the line
    typedef logic [`INDEX_BITS-1:0] line_idx_t;

    // pc bits 31..8 stored per line
    typedef logic [`XLEN-`INDEX_BITS-`OFFSET_BITS-1:0] tag_t;

    // word inside a line
    typedef logic [$clog2(`LINE_WORDS)-1:0] word_sel_t;

    // refill sequencer states
    typedef enum logic [1:0] {
        IDLE,       // wait for a miss
        REQ,        // mem_req high until mem_ack
        RELEASE,    // mem_req low until mem_ack drops
        WRITE       // one-cycle line write into the array
    } refill_state_t;

endpackage

// File: src/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// address and pc width
`define XLEN 32

// direct-mapped cache geometry
`define ICACHE_LINES 32
`define LINE_WORDS 2             // two 32-bit words, 8-byte line
`define OFFSET_BITS 3            // byte offset inside a line
`define INDEX_BITS 5             // log2 of ICACHE_LINES

// slots fetched per cycle, slot 2 is the oldest
`define FETCH_WIDTH 3

`endif
